// ==== Bender.yml ====
package:
  name: async_fifo

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/afifo_pkg.sv
      - src/dual_port_ram.sv
      - async_fifo/wr_ptr_ctrl.sv
      - async_fifo/rd_ptr_ctrl.sv
      - async_fifo/async_fifo.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/fifo_checker.sv
      - tests/tb_async_fifo.sv

// ==== async_fifo/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  // Write domain
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_en,
  input  afifo_pkg::data_t  wr_data,
  output logic              full,
  output logic              afull,
  // Read domain
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  output afifo_pkg::data_t  rd_data,
  output logic              empty,
  output logic              aempty
);

  logic              wr_vld;
  afifo_pkg::addr_t  wr_addr;
  afifo_pkg::ptr_t   wr_gray;   // Crosses into rd_clk

  logic              rd_vld;
  afifo_pkg::addr_t  rd_addr;
  afifo_pkg::ptr_t   rd_gray;   // Crosses into wr_clk

  wr_ptr_ctrl u_wr_ptr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_vld   (wr_vld),
    .wr_addr  (wr_addr),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull)
  );

  rd_ptr_ctrl u_rd_ptr_ctrl (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_vld   (rd_vld),
    .rd_addr  (rd_addr),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Storage written on wr_clk and read out on rd_clk
  dual_port_ram u_dual_port_ram (
    .wr_clk   (wr_clk),
    .wr_vld   (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_vld   (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== async_fifo/rd_ptr_ctrl.sv ====
`timescale 1ns/1ps

`include "afifo_cfg.svh"

module rd_ptr_ctrl (
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  input  afifo_pkg::ptr_t   wr_gray,
  output logic              rd_vld,
  output afifo_pkg::addr_t  rd_addr,
  output afifo_pkg::ptr_t   rd_gray,
  output logic              empty,
  output logic              aempty
);

  afifo_pkg::ptr_t   rd_bin;
  afifo_pkg::ptr_t   rd_bin_nxt;
  afifo_pkg::ptr_t   rd_gray_nxt;

  afifo_pkg::ptr_t   wr_gray_sync1;
  afifo_pkg::ptr_t   wr_gray_sync2;
  afifo_pkg::ptr_t   wr_bin_sync;

  afifo_pkg::level_t rd_level_nxt;
  logic              empty_nxt;
  logic              aempty_nxt;

  // Accept only while data is present
  assign rd_vld = rd_en & ~empty;

  assign rd_bin_nxt  = rd_bin + afifo_pkg::ptr_t'(rd_vld);
  assign rd_gray_nxt = afifo_pkg::bin2gray(rd_bin_nxt);
  assign rd_addr     = rd_bin[`AFIFO_ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // Write pointer into the read domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  assign wr_bin_sync = afifo_pkg::gray2bin(wr_gray_sync2);

  // Pointers meet when the last written word is consumed
  assign empty_nxt = (rd_gray_nxt == wr_gray_sync2);

  // Occupancy lags new writes, so aempty releases late and never early
  assign rd_level_nxt = wr_bin_sync - rd_bin_nxt;
  assign aempty_nxt   = (rd_level_nxt <= afifo_pkg::level_t'(`AFIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

// ==== async_fifo/wr_ptr_ctrl.sv ====
`timescale 1ns/1ps

`include "afifo_cfg.svh"

module wr_ptr_ctrl (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_en,
  input  afifo_pkg::ptr_t   rd_gray,
  output logic              wr_vld,
  output afifo_pkg::addr_t  wr_addr,
  output afifo_pkg::ptr_t   wr_gray,
  output logic              full,
  output logic              afull
);

  afifo_pkg::ptr_t   wr_bin;
  afifo_pkg::ptr_t   wr_bin_nxt;
  afifo_pkg::ptr_t   wr_gray_nxt;

  afifo_pkg::ptr_t   rd_gray_sync1;
  afifo_pkg::ptr_t   rd_gray_sync2;
  afifo_pkg::ptr_t   rd_bin_sync;
  afifo_pkg::ptr_t   rd_gray_full;   // Read pointer one lap ahead

  afifo_pkg::level_t wr_level_nxt;
  logic              full_nxt;
  logic              afull_nxt;

  // Accept only while not full
  assign wr_vld = wr_en & ~full;

  assign wr_bin_nxt  = wr_bin + afifo_pkg::ptr_t'(wr_vld);
  assign wr_gray_nxt = afifo_pkg::bin2gray(wr_bin_nxt);
  assign wr_addr     = wr_bin[`AFIFO_ADDR_WIDTH-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt; // Registered so only one bit moves per write
    end
  end

  // Two-flop synchronizer for the read pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  assign rd_bin_sync = afifo_pkg::gray2bin(rd_gray_sync2);

  // In Gray code a full lap differs in the two top bits only
  assign rd_gray_full = {~rd_gray_sync2[`AFIFO_ADDR_WIDTH:`AFIFO_ADDR_WIDTH-1],
                         rd_gray_sync2[`AFIFO_ADDR_WIDTH-2:0]};

  assign full_nxt = (wr_gray_nxt == rd_gray_full);

  // Fill count seen from the write side is never below the true count
  assign wr_level_nxt = wr_bin_nxt - rd_bin_sync;
  assign afull_nxt    = (wr_level_nxt >= afifo_pkg::level_t'(`AFIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

// ==== common/afifo_cfg.svh ====
`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

// FIFO geometry

// Width of one data word
`define AFIFO_DATA_WIDTH 8

// RAM address width
`define AFIFO_ADDR_WIDTH 4

// Storage depth in words equals 2**AFIFO_ADDR_WIDTH
`define AFIFO_DEPTH 16

// Almost-full when the fill count is at or above this
`define AFIFO_AFULL 12

// Almost-empty when the fill count is at or below this
`define AFIFO_AEMPTY 2

`endif

// ==== common/afifo_pkg.sv ====
`include "afifo_cfg.svh"

package afifo_pkg;

  typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`AFIFO_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AFIFO_ADDR_WIDTH:0]   ptr_t;   // Extra MSB is the wrap bit
  typedef logic [`AFIFO_ADDR_WIDTH:0]   level_t; // 0 .. AFIFO_DEPTH

  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits from the MSB down to it
  function automatic ptr_t gray2bin(ptr_t gray);
    ptr_t bin;
    bin = gray;
    for (int i = 1; i <= `AFIFO_ADDR_WIDTH; i++) begin
      bin = bin ^ (gray >> i);
    end
    return bin;
  endfunction

endpackage

// ==== src.f ====
+incdir+common
common/afifo_pkg.sv
src/dual_port_ram.sv
async_fifo/wr_ptr_ctrl.sv
async_fifo/rd_ptr_ctrl.sv
async_fifo/async_fifo.sv
tests/fifo_checker.sv
tests/tb_async_fifo.sv

// ==== src/dual_port_ram.sv ====
`timescale 1ns/1ps

`include "afifo_cfg.svh"

module dual_port_ram (
  input  logic              wr_clk,
  input  logic              wr_vld,
  input  afifo_pkg::addr_t  wr_addr,
  input  afifo_pkg::data_t  wr_data,
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_vld,
  input  afifo_pkg::addr_t  rd_addr,
  output afifo_pkg::data_t  rd_data
);

  afifo_pkg::data_t mem [`AFIFO_DEPTH];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (wr_vld) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port that holds its value between accepted reads
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_vld) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== tests/fifo_checker.sv ====
`timescale 1ns/1ps

`include "afifo_cfg.svh"

module fifo_checker (
  input  logic             wr_clk,
  input  logic             wr_rst_n,
  input  logic             wr_en,
  input  afifo_pkg::data_t wr_data,
  input  logic             full,
  input  logic             afull,
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_en,
  input  afifo_pkg::data_t rd_data,
  input  logic             empty,
  input  logic             aempty,
  input  logic             settle_req,
  input  logic             end_req,
  output int               data_errs,
  output int               flag_errs,
  output int               misc_errs
);

  afifo_pkg::data_t model_q [$];
  afifo_pkg::data_t exp_data;
  afifo_pkg::data_t held_data;
  logic             data_pending = 1'b0;  // A popped word is due on rd_data
  logic             hold_pending = 1'b0;  // Read tried while empty
  int               push_cnt = 0;
  int               read_cnt = 0;         // Popped words seen on rd_data
  int               data_err_cnt = 0;
  int               flag_err_cnt = 0;
  int               misc_err_cnt = 0;

  assign data_errs = data_err_cnt;
  assign flag_errs = flag_err_cnt;
  assign misc_errs = misc_err_cnt;

  // Flags of an idle FIFO holding count words as {full, afull, empty, aempty}
  function automatic logic [3:0] expected_flags(afifo_pkg::level_t count);
    logic [3:0] flags;
    flags[3] = (count == `AFIFO_DEPTH);
    flags[2] = (count >= `AFIFO_AFULL);
    flags[1] = (count == 0);
    flags[0] = (count <= `AFIFO_AEMPTY);
    return flags;
  endfunction

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %0b got %0b", $time, name, exp, act);
      flag_err_cnt++;
    end
  endtask

  task automatic compare_data(input afifo_pkg::data_t exp, input afifo_pkg::data_t act);
    if (exp !== act) begin
      $display("Fail at %0t: rd_data expected %02h got %02h", $time, exp, act);
      data_err_cnt++;
    end
  endtask

  task automatic check_settled();
    logic [3:0] exp;
    exp = expected_flags(afifo_pkg::level_t'(model_q.size()));
    compare_flag("full", exp[3], full);
    compare_flag("afull", exp[2], afull);
    compare_flag("empty", exp[1], empty);
    compare_flag("aempty", exp[0], aempty);
  endtask

  task automatic check_drained();
    if (model_q.size() != 0) begin
      $display("Model queue still holds %0d words at the end of the run", model_q.size());
      misc_err_cnt++;
    end
    if (push_cnt != read_cnt) begin
      $display("%0d words were written but %0d were read out", push_cnt, read_cnt);
      misc_err_cnt++;
    end
  endtask

  // Flags and output register straight out of reset
  always @(posedge rd_rst_n) begin
    #1;
    compare_flag("full", 1'b0, full);
    compare_flag("afull", 1'b0, afull);
    compare_flag("empty", 1'b1, empty);
    compare_flag("aempty", 1'b1, aempty);
    compare_data('0, rd_data);
  end

  always @(posedge wr_clk) begin
    if (wr_rst_n) begin
      if (model_q.size() == `AFIFO_DEPTH) compare_flag("full", 1'b1, full);
      if (wr_en && !full) begin
        if (model_q.size() == `AFIFO_DEPTH) begin
          $display("Write accepted at %0t while the FIFO already held every word", $time);
          misc_err_cnt++;
        end
        model_q.push_back(wr_data);
        push_cnt++;
      end
    end
  end

  always @(posedge rd_clk) begin
    if (rd_rst_n) begin
      if (data_pending) begin
        compare_data(exp_data, rd_data);
        read_cnt++;
      end
      if (hold_pending) compare_data(held_data, rd_data);  // Must hold
      data_pending = 1'b0;
      hold_pending = 1'b0;
      if (model_q.size() == 0) compare_flag("empty", 1'b1, empty);
      if (rd_en && !empty) begin
        if (model_q.size() == 0) begin
          $display("Read accepted at %0t with nothing written", $time);
          misc_err_cnt++;
        end else begin
          exp_data = model_q.pop_front();
          data_pending = 1'b1;
        end
      end else if (rd_en) begin
        held_data = rd_data;
        hold_pending = 1'b1;
      end
      if (settle_req) check_settled();
      if (end_req) check_drained();
    end
  end

endmodule

// ==== tests/tb_async_fifo.sv ====
`timescale 1ns/1ps

module tb_async_fifo;

  // Reset, fill, drain, two random halves, final drain and five quiet periods
  // come to about 3200 rd_clk cycles
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int RAND_RD_CYCLES = 1500;
  localparam int RAND_WR_CYCLES = RAND_RD_CYCLES * 40 / 28;  // Same span on wr_clk
  localparam int QUIET_CYCLES   = 10;
  localparam int EXTRA_TRIES    = 4;  // Strobes held on past full or empty

  logic             wr_clk;
  logic             wr_rst_n;
  logic             wr_en;
  afifo_pkg::data_t wr_data;
  logic             full;
  logic             afull;
  logic             rd_clk;
  logic             rd_rst_n;
  logic             rd_en;
  afifo_pkg::data_t rd_data;
  logic             empty;
  logic             aempty;
  logic             settle_req;
  logic             end_req;
  int               data_errs;
  int               flag_errs;
  int               misc_errs;
  int               rd_cycles = 0;

  initial begin
    rd_clk = 1'b0;
    forever #20 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #14 wr_clk = ~wr_clk;
  end

  async_fifo async_fifo_inst (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  fifo_checker u_fifo_checker (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .full       (full),
    .afull      (afull),
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .empty      (empty),
    .aempty     (aempty),
    .settle_req (settle_req),
    .end_req    (end_req),
    .data_errs  (data_errs),
    .flag_errs  (flag_errs),
    .misc_errs  (misc_errs)
  );

  always @(posedge rd_clk) begin
    rd_cycles++;
    if (rd_cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Writes until full, then keeps trying a few more times
  task automatic fill_fifo();
    int extra;
    extra = 0;
    while (extra < EXTRA_TRIES) begin
      @(posedge wr_clk);
      #2;
      if (full) extra++;
      wr_en   = 1'b1;
      wr_data = afifo_pkg::data_t'($urandom);
    end
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
  endtask

  task automatic drain_fifo();
    int extra;
    extra = 0;
    while (extra < EXTRA_TRIES) begin
      @(posedge rd_clk);
      #2;
      if (empty) extra++;
      rd_en = 1'b1;
    end
    @(posedge rd_clk);
    #2;
    rd_en = 1'b0;
  endtask

  task automatic random_traffic(input int wr_pct, input int rd_pct);
    fork
      begin
        repeat (RAND_WR_CYCLES) begin
          @(posedge wr_clk);
          #2;
          wr_en   = (($urandom % 100) < wr_pct);
          wr_data = afifo_pkg::data_t'($urandom);
        end
        @(posedge wr_clk);
        #2;
        wr_en = 1'b0;
      end
      begin
        repeat (RAND_RD_CYCLES) begin
          @(posedge rd_clk);
          #2;
          rd_en = (($urandom % 100) < rd_pct);
        end
        @(posedge rd_clk);
        #2;
        rd_en = 1'b0;
      end
    join
  endtask

  // Idle long enough for both synchronizers, then compare the flags
  task automatic quiet_period();
    repeat (QUIET_CYCLES) @(posedge rd_clk);
    #2;
    settle_req = 1'b1;
    @(posedge rd_clk);
    #2;
    settle_req = 1'b0;
  endtask

  initial begin
    wr_rst_n   = 1'b0;
    rd_rst_n   = 1'b0;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    wr_data    = '0;
    settle_req = 1'b0;
    end_req    = 1'b0;
    void'($urandom(32'h586d517e));
    repeat (4) @(posedge rd_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    fill_fifo();
    quiet_period();
    drain_fifo();
    quiet_period();
    random_traffic(70, 40);
    quiet_period();
    random_traffic(40, 70);
    quiet_period();
    drain_fifo();
    quiet_period();

    end_req = 1'b1;
    @(posedge rd_clk);
    #2;
    end_req = 1'b0;

    $display("Errors: data %0d, flags %0d, other %0d", data_errs, flag_errs, misc_errs);
    if (data_errs == 0 && flag_errs == 0 && misc_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
